// File: Makefile
TOP = ad9528_cfg_tb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: rtl/ad9528_cfg_top.sv
`timescale 1ns/1ps

module ad9528_cfg_top (
    input  logic                      CLK,
    input  logic                      RESET,
    input  cg_regmap_pkg::word_t      wdata,
    input  cg_regmap_pkg::strb_t      wstrb,
    input  cg_regmap_pkg::word_addr_t waddr,
    input  logic                      wvalid,
    input  cg_regmap_pkg::word_addr_t raddr,
    output cg_regmap_pkg::word_t      rdata,
    input  cg_regmap_pkg::word_t      request_interval,
    output logic                      pll1_locked,
    output logic                      pll2_locked,
    output logic                      configure_complete,
    output logic                      spi_cs_n,
    output logic                      spi_sck,
    output logic                      spi_mosi,
    input  logic                      spi_miso,
    output logic                      dev_rst_n
);
    import cg_regmap_pkg::*;
    import cg_ctrl_pkg::*;

    // queue head
    logic       q_empty;
    word_t      q_data;
    strb_t      q_strb;
    word_addr_t q_addr;
    logic       pop;

    // spi engine
    frame_t     frame;
    logic       start;
    logic       busy;
    byte_t      rx_byte;
    logic       rx_valid;

    // read-back into shadow
    logic       shadow_we;
    byte_addr_t shadow_addr;
    byte_t      shadow_byte;

    write_queue write_queue_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .push    (wvalid),
        .in_data (wdata),
        .in_strb (wstrb),
        .in_addr (waddr),
        .pop     (pop),
        .empty   (q_empty),
        .q_data  (q_data),
        .q_strb  (q_strb),
        .q_addr  (q_addr)
    );

    cfg_sequencer cfg_sequencer_i (
        .CLK                (CLK),
        .RESET              (RESET),
        .request_interval   (request_interval),
        .q_empty            (q_empty),
        .q_data             (q_data),
        .q_strb             (q_strb),
        .q_addr             (q_addr),
        .pop                (pop),
        .frame              (frame),
        .start              (start),
        .busy               (busy),
        .rx_valid           (rx_valid),
        .rx_byte            (rx_byte),
        .shadow_we          (shadow_we),
        .shadow_addr        (shadow_addr),
        .shadow_byte        (shadow_byte),
        .configure_complete (configure_complete),
        .dev_rst_n          (dev_rst_n)
    );

    spi_master spi_master_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .frame    (frame),
        .start    (start),
        .busy     (busy),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cs_n     (spi_cs_n),
        .sck      (spi_sck),
        .mosi     (spi_mosi),
        .miso     (spi_miso)
    );

    shadow_regmap shadow_regmap_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .we          (shadow_we),
        .waddr       (shadow_addr),
        .wbyte       (shadow_byte),
        .raddr       (raddr),
        .rdata       (rdata),
        .pll1_locked (pll1_locked),
        .pll2_locked (pll2_locked)
    );

endmodule

// File: rtl/cfg_sequencer.sv
`timescale 1ns/1ps
`include "cg_settings.svh"

module cfg_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  cg_regmap_pkg::word_t      request_interval,
    input  logic                      q_empty,
    input  cg_regmap_pkg::word_t      q_data,
    input  cg_regmap_pkg::strb_t      q_strb,
    input  cg_regmap_pkg::word_addr_t q_addr,
    output logic                      pop,
    output cg_ctrl_pkg::frame_t       frame,
    output logic                      start,
    input  logic                      busy,
    input  logic                      rx_valid,
    input  cg_regmap_pkg::byte_t      rx_byte,
    output logic                      shadow_we,
    output cg_regmap_pkg::byte_addr_t shadow_addr,
    output cg_regmap_pkg::byte_t      shadow_byte,
    output logic                      configure_complete,
    output logic                      dev_rst_n
);
    import cg_regmap_pkg::*;
    import cg_ctrl_pkg::*;

    seq_state_t state;
    word_t      interval_cnt;
    logic       sweep_due;
    byte_addr_t rd_addr;   // current read-back register
    word_t      data_reg;  // lane 0 always in [7:0]
    strb_t      strb_reg;
    word_addr_t addr_reg;
    lane_t      lane;

    assign sweep_due = (interval_cnt >= request_interval - 1'b1);
    assign pop       = (state == WR_LOAD);  // head changes next cycle

    always_ff @(posedge CLK) begin
        if (RESET) begin
            dev_rst_n <= 1'b0;
        end else begin
            dev_rst_n <= 1'b1;
        end
    end

    // runs outside read-back, holds once saturated
    always_ff @(posedge CLK) begin
        if (RESET) begin
            interval_cnt <= '0;
        end else if (state == RD_SEND || state == RD_WAIT) begin
            interval_cnt <= '0;
        end else if (!sweep_due) begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state              <= IDLE_READ_CHECK;
            start              <= 1'b0;
            shadow_we          <= 1'b0;
            configure_complete <= 1'b0;
        end else begin
            start     <= 1'b0;
            shadow_we <= 1'b0;
            case (state)
                IDLE_READ_CHECK: begin
                    state <= sweep_due ? RD_SEND : IDLE_WRITE_CHECK;
                end
                IDLE_WRITE_CHECK: begin
                    state <= q_empty ? IDLE_READ_CHECK : WR_LOAD;
                end
                RD_SEND: begin
                    if (!busy) begin
                        start <= 1'b1;
                        state <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    if (rx_valid) begin
                        shadow_we <= 1'b1;
                        if (rd_addr == `CG_READBACK_LAST) begin
                            state <= IDLE_WRITE_CHECK;  // sweep done
                        end else begin
                            state <= RD_SEND;
                        end
                    end
                end
                WR_LOAD: begin
                    configure_complete <= 1'b0;  // new work taken
                    state              <= WR_CHECK;
                end
                WR_CHECK: begin
                    state <= strb_reg[0] ? WR_SEND : WR_NEXT;
                end
                WR_SEND: begin
                    if (!busy) begin
                        start <= 1'b1;
                        state <= WR_NEXT;
                    end
                end
                default: begin
                    if (lane != 2'd3) begin
                        state <= WR_CHECK;
                    end else if (q_empty) begin
                        configure_complete <= 1'b1;
                        state              <= IDLE_READ_CHECK;
                    end else begin
                        state <= WR_LOAD;  // keep draining the burst
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        case (state)
            IDLE_READ_CHECK: begin
                rd_addr <= `CG_READBACK_FIRST;
            end
            RD_SEND: begin
                frame <= {1'b1, 2'b00, 2'b00, rd_addr, 8'h00};  // single-byte read
            end
            RD_WAIT: begin
                if (rx_valid) begin
                    shadow_addr <= rd_addr;
                    shadow_byte <= rx_byte;
                    rd_addr     <= rd_addr + 1'b1;
                end
            end
            WR_LOAD: begin
                data_reg <= q_data;
                strb_reg <= q_strb;
                addr_reg <= q_addr;
                lane     <= '0;
            end
            WR_SEND: begin
                frame <= {1'b0, 2'b00, 2'b00, addr_reg, lane, data_reg[7:0]};  // waddr*4+lane
            end
            WR_NEXT: begin
                data_reg <= data_reg >> 8;
                strb_reg <= strb_reg >> 1;
                lane     <= lane + 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/cg_ctrl_pkg.sv
package cg_ctrl_pkg;

    localparam int FRAME_BITS = 24;

    // [23] r/w (1 = read), [22:21] zero for one byte,
    // [20:8] register address, [7:0] data
    typedef logic [FRAME_BITS-1:0] frame_t;

    typedef enum logic [2:0] {
        IDLE_READ_CHECK,   // sweep due?
        IDLE_WRITE_CHECK,  // anything queued?
        RD_SEND,
        RD_WAIT,           // wait for rx byte
        WR_LOAD,           // latch and pop head word
        WR_CHECK,          // strobe of current lane
        WR_SEND,
        WR_NEXT            // shift to next lane
    } seq_state_t;

endpackage

// File: rtl/cg_regmap_pkg.sv
package cg_regmap_pkg;

    // device side
    typedef logic [7:0]  byte_t;       // one device register
    typedef logic [10:0] byte_addr_t;  // up to 0x7ff

    // host side
    typedef logic [31:0] word_t;       // host data word
    typedef logic [3:0]  strb_t;       // one strobe per byte lane
    typedef logic [8:0]  word_addr_t;  // 512 words
    typedef logic [1:0]  lane_t;       // byte within a word

endpackage

// File: rtl/cg_settings.svh
`ifndef CG_SETTINGS_SVH
`define CG_SETTINGS_SVH

`define CG_QUEUE_DEPTH      512      // host words held before loss
`define CG_SPI_HALF_PERIOD  6        // CLK cycles per SCK half period

`define CG_READBACK_FIRST   11'h000
`define CG_READBACK_LAST    11'h509  // last register of the map

// identity bytes of the part
`define CG_ID_ADDR0         11'h003
`define CG_ID_ADDR1         11'h00C
`define CG_ID_ADDR2         11'h00D
`define CG_ID_VAL0          8'h05
`define CG_ID_VAL1          8'h56
`define CG_ID_VAL2          8'h04

`define CG_STATUS_ADDR      11'h508  // pll lock bits

`endif

// File: rtl/shadow_regmap.sv
`timescale 1ns/1ps
`include "cg_settings.svh"

module shadow_regmap (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      we,
    input  cg_regmap_pkg::byte_addr_t waddr,
    input  cg_regmap_pkg::byte_t      wbyte,
    input  cg_regmap_pkg::word_addr_t raddr,
    output cg_regmap_pkg::word_t      rdata,
    output logic                      pll1_locked,
    output logic                      pll2_locked
);
    import cg_regmap_pkg::*;

    localparam int WORDS = 2 ** $bits(word_addr_t);
    localparam int NCAP  = 4;

    // id0, id1, id2, status
    localparam byte_addr_t CAP_ADDR [NCAP] = '{
        `CG_ID_ADDR0, `CG_ID_ADDR1, `CG_ID_ADDR2, `CG_STATUS_ADDR
    };

    word_t mem [WORDS];
    byte_t cap [NCAP];
    lane_t wlane;
    logic  chip_present;

    assign wlane = waddr[1:0];

    // byte 4w+k lands in bits 8k+7:8k of word w
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr[10:2]][8 * wlane +: 8] <= wbyte;
        end
        rdata <= mem[raddr];
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            cap <= '{default: '0};
        end else if (we) begin
            for (int i = 0; i < NCAP; i++) begin
                if (waddr == CAP_ADDR[i]) begin
                    cap[i] <= wbyte;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            chip_present <= 1'b0;
            pll1_locked  <= 1'b0;
            pll2_locked  <= 1'b0;
        end else begin
            chip_present <= (cap[0] == `CG_ID_VAL0) && (cap[1] == `CG_ID_VAL1)
                            && (cap[2] == `CG_ID_VAL2);
            pll1_locked  <= cap[3][0] & chip_present;  // lock bits mean nothing without the part
            pll2_locked  <= cap[3][1] & chip_present;
        end
    end

endmodule

// File: rtl/spi_master.sv
`timescale 1ns/1ps
`include "cg_settings.svh"

module spi_master #(
    parameter int HALF_PERIOD = `CG_SPI_HALF_PERIOD
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  cg_ctrl_pkg::frame_t  frame,
    input  logic                 start,
    output logic                 busy,
    output cg_regmap_pkg::byte_t rx_byte,
    output logic                 rx_valid,
    output logic                 cs_n,
    output logic                 sck,
    output logic                 mosi,
    input  logic                 miso
);
    import cg_ctrl_pkg::*;
    import cg_regmap_pkg::*;

    localparam int DIV_W = $clog2(HALF_PERIOD + 1);
    localparam int BIT_W = $clog2(FRAME_BITS);

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_TAIL    // cs_n hold after the last falling edge
    } spi_state_t;

    spi_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             half_tick;
    frame_t           tx_shift;
    byte_t            rx_shift;

    assign half_tick = (div_cnt == DIV_W'(HALF_PERIOD - 1));
    assign mosi      = tx_shift[FRAME_BITS-1] & ~cs_n;  // quiet low between frames
    assign rx_byte   = rx_shift;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= SPI_IDLE;
            cs_n     <= 1'b1;
            sck      <= 1'b0;
            busy     <= 1'b0;
            rx_valid <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    if (start) begin
                        state   <= SPI_SHIFT;
                        cs_n    <= 1'b0;
                        busy    <= 1'b1;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                SPI_SHIFT: begin
                    if (half_tick) begin
                        div_cnt <= '0;
                        sck     <= ~sck;
                        if (sck) begin  // falling edge closes a bit
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                                state <= SPI_TAIL;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    if (half_tick) begin
                        div_cnt  <= '0;
                        state    <= SPI_IDLE;
                        cs_n     <= 1'b1;
                        busy     <= 1'b0;
                        rx_valid <= 1'b1;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == SPI_IDLE && start) begin
            tx_shift <= frame;
        end else if (state == SPI_SHIFT && half_tick && sck) begin
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};  // next bit as sck falls
        end
        if (state == SPI_SHIFT && half_tick && !sck) begin
            rx_shift <= {rx_shift[6:0], miso};  // sampled as sck rises
        end
    end

endmodule

// File: rtl/write_queue.sv
`timescale 1ns/1ps
`include "cg_settings.svh"

module write_queue #(
    parameter int DEPTH = `CG_QUEUE_DEPTH
) (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      push,
    input  cg_regmap_pkg::word_t      in_data,
    input  cg_regmap_pkg::strb_t      in_strb,
    input  cg_regmap_pkg::word_addr_t in_addr,
    input  logic                      pop,
    output logic                      empty,
    output cg_regmap_pkg::word_t      q_data,
    output cg_regmap_pkg::strb_t      q_strb,
    output cg_regmap_pkg::word_addr_t q_addr
);
    import cg_regmap_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t      mem_data [DEPTH];
    strb_t      mem_strb [DEPTH];
    word_addr_t mem_addr [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign do_push = push && (count != CNT_W'(DEPTH));  // word lost when full
    assign do_pop  = pop && !empty;

    assign q_data = mem_data[rd_ptr];  // head visible without a request
    assign q_strb = mem_strb[rd_ptr];
    assign q_addr = mem_addr[rd_ptr];

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem_data[wr_ptr] <= in_data;
            mem_strb[wr_ptr] <= in_strb;
            mem_addr[wr_ptr] <= in_addr;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: verification/ad9528_cfg_tb.sv
`timescale 1ns/1ps
`include "cg_settings.svh"

module ad9528_cfg_tb;
    import cg_regmap_pkg::*;

    localparam int WAIT_LIMIT = 1000000;  // cycle budget above two sweeps

    logic       CLK = 1'b0;
    logic       RESET;
    word_t      wdata;
    strb_t      wstrb;
    word_addr_t waddr;
    logic       wvalid;
    word_addr_t raddr;
    word_t      rdata;
    word_t      request_interval;
    logic       pll1_locked;
    logic       pll2_locked;
    logic       configure_complete;
    logic       spi_cs_n;
    logic       spi_sck;
    logic       spi_mosi;
    logic       spi_miso;
    logic       dev_rst_n;

    byte_t      step_kind [$];  // W and R lines in file order
    word_t      step_a [$];
    word_t      step_b [$];
    word_t      step_c [$];
    byte_addr_t preload_addr [$];
    byte_t      preload_data [$];
    byte_addr_t exp_log_addr [$];
    byte_t      exp_log_data [$];

    logic [15:0] lfsr;
    int          checks;
    int          errors;

    always #2 CLK = ~CLK;

    ad9528_cfg_top ad9528_cfg_top_i (
        .CLK                (CLK),
        .RESET              (RESET),
        .wdata              (wdata),
        .wstrb              (wstrb),
        .waddr              (waddr),
        .wvalid             (wvalid),
        .raddr              (raddr),
        .rdata              (rdata),
        .request_interval   (request_interval),
        .pll1_locked        (pll1_locked),
        .pll2_locked        (pll2_locked),
        .configure_complete (configure_complete),
        .spi_cs_n           (spi_cs_n),
        .spi_sck            (spi_sck),
        .spi_mosi           (spi_mosi),
        .spi_miso           (spi_miso),
        .dev_rst_n          (dev_rst_n)
    );

    ad9528_spi_model spi_model_i (
        .cs_n (spi_cs_n),
        .sck  (spi_sck),
        .mosi (spi_mosi),
        .miso (spi_miso)
    );

    task automatic check_value(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    task automatic load_vectors(output logic ok);
        int    fd;
        int    c;
        int    n;
        byte_t ch;
        word_t a;
        word_t b;
        word_t d;
        ok = 1'b0;
        fd = $fopen("verification/ad9528_cfg_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file");
            return;
        end
        c = $fgetc(fd);
        while (c >= 0) begin
            ch = 8'(c);
            n  = -1;
            if (ch == "#") begin
                while (c >= 0 && c != 10) begin
                    c = $fgetc(fd);
                end
            end else if (ch == "I") begin
                n = ($fscanf(fd, " %h %h", a, b) == 2) ? 1 : 0;
                preload_addr.push_back(11'(a));
                preload_data.push_back(8'(b));
            end else if (ch == "W") begin
                n = ($fscanf(fd, " %h %h %h", a, b, d) == 3) ? 1 : 0;
                step_kind.push_back(ch);
                step_a.push_back(a);
                step_b.push_back(b);
                step_c.push_back(d);
            end else if (ch == "R") begin
                n = ($fscanf(fd, " %h %h", a, d) == 2) ? 1 : 0;
                step_kind.push_back(ch);
                step_a.push_back(a);
                step_b.push_back('0);
                step_c.push_back(d);
            end
            if (n == 0) begin
                errors++;
                $display("a line of the vector file could not be parsed");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        ok = (errors == 0);
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois form of x^16+x^14+x^13+x^11+1
    endfunction

    task automatic next_gap(output int gap);
        int i;
        gap = 0;
        for (i = 0; i < 3; i++) begin
            lfsr = lfsr_step(lfsr);
            gap  = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_idle_outputs(input logic rst_n_exp);
        check_value("configure_complete", 32'(configure_complete), 32'h0);
        check_value("pll1_locked", 32'(pll1_locked), 32'h0);
        check_value("pll2_locked", 32'(pll2_locked), 32'h0);
        check_value("spi_cs_n", 32'(spi_cs_n), 32'h1);
        check_value("spi_sck", 32'(spi_sck), 32'h0);
        check_value("dev_rst_n", 32'(dev_rst_n), 32'(rst_n_exp));
    endtask

    task automatic apply_reset;
        int i;
        @(posedge CLK);
        for (i = 0; i < preload_addr.size(); i++) begin
            spi_model_i.preload_byte(preload_addr[i], preload_data[i]);
        end
        for (i = 1; i < 8; i++) begin
            @(negedge CLK);
            check_idle_outputs(1'b0);
            @(posedge CLK);
        end
        RESET <= 1'b0;
        @(posedge CLK);
        @(negedge CLK);
        check_idle_outputs(1'b1);  // first cycle out of reset
    endtask

    task automatic push_word(input word_t addr, input word_t strb, input word_t data);
        int lane;
        int gap;
        @(posedge CLK);
        waddr  <= 9'(addr);
        wstrb  <= 4'(strb);
        wdata  <= data;
        wvalid <= 1'b1;
        @(posedge CLK);
        wvalid <= 1'b0;
        for (lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                exp_log_addr.push_back(11'(addr * 4 + lane));
                exp_log_data.push_back(data[8 * lane +: 8]);
            end
        end
        next_gap(gap);
        repeat (gap) @(posedge CLK);
    endtask

    task automatic wait_complete(input logic level, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge CLK);
            ok = (configure_complete === level);
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timed out waiting for configure_complete to become %0b", level);
        end
    endtask

    task automatic wait_log_count(input int target, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge CLK);
            ok = (spi_model_i.log_count >= target);
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timed out waiting for %0d write frames at the device", target);
        end
    endtask

    task automatic wait_sweep(input int target, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge CLK);
            ok = (spi_model_i.sweep_count >= target);
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timed out waiting for a read-back sweep to finish");
        end
    endtask

    task automatic check_log(input int base);
        int k;
        for (k = base; k < exp_log_addr.size(); k++) begin
            check_value($sformatf("log_addr[%0d]", k), 32'(spi_model_i.log_addr[k]),
                        32'(exp_log_addr[k]));
            check_value($sformatf("log_data[%0d]", k), 32'(spi_model_i.log_data[k]),
                        32'(exp_log_data[k]));
        end
    endtask

    task automatic check_pll;
        logic present;
        present = (spi_model_i.regs[`CG_ID_ADDR0] == `CG_ID_VAL0)
                  && (spi_model_i.regs[`CG_ID_ADDR1] == `CG_ID_VAL1)
                  && (spi_model_i.regs[`CG_ID_ADDR2] == `CG_ID_VAL2);
        check_value("pll1_locked", 32'(pll1_locked),
                    32'(present & spi_model_i.regs[`CG_STATUS_ADDR][0]));
        check_value("pll2_locked", 32'(pll2_locked),
                    32'(present & spi_model_i.regs[`CG_STATUS_ADDR][1]));
    endtask

    task automatic check_read(input word_t addr, input word_t expected);
        @(posedge CLK);
        raddr <= 9'(addr);
        @(posedge CLK);
        @(negedge CLK);
        check_value($sformatf("rdata[0x%03h]", 9'(addr)), rdata, expected);
    endtask

    task automatic run_test;
        int   idx;
        int   log_base;
        int   sweeps;
        logic pushed;
        logic ok;
        apply_reset();
        idx = 0;
        while (idx < step_kind.size()) begin
            log_base = exp_log_addr.size();
            pushed   = 1'b0;
            while (idx < step_kind.size() && step_kind[idx] == "W") begin
                push_word(step_a[idx], step_b[idx], step_c[idx]);
                pushed = 1'b1;
                idx++;
            end
            if (pushed) begin
                wait_complete(1'b0, ok);
                if (!ok) return;
                wait_complete(1'b1, ok);
                if (!ok) return;
                wait_log_count(exp_log_addr.size(), ok);  // last frame may still be shifting
                if (!ok) return;
                check_log(log_base);
            end
            sweeps = spi_model_i.sweep_count;
            wait_sweep(sweeps + 1, ok);
            if (!ok) return;
            repeat (5) @(posedge CLK);  // shadow write, capture, pll registers
            @(negedge CLK);
            check_pll();
            while (idx < step_kind.size() && step_kind[idx] == "R") begin
                check_read(step_a[idx], step_c[idx]);
                idx++;
            end
        end
        check_value("write frame count", 32'(spi_model_i.log_count), 32'(exp_log_addr.size()));
        check_value("bad frame count", 32'(spi_model_i.bad_frames), 32'h0);
    endtask

    initial begin
        logic ok;
        RESET            = 1'b1;
        wdata            = '0;
        wstrb            = '0;
        waddr            = '0;
        wvalid           = 1'b0;
        raddr            = '0;
        request_interval = 32'd64;
        checks           = 0;
        errors           = 0;
        lfsr             = 16'd18614;
        load_vectors(ok);
        if (ok) begin
            run_test();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verification/ad9528_cfg_vectors.txt
# I byte_addr data          preload one device register
# W waddr wstrb wdata       host write word
# R raddr word              shadow word expected after the next sweep
I 000 18
I 001 2C
I 002 00
I 003 05
I 00C 56
I 00D 04
I 00E 81
I 00F 3C
I 045 6E
I 047 19
I 080 07
I 081 A0
I 082 F2
I 508 01
W 010 F 11223344
W 011 5 AABBCCDD
W 020 8 DEADBEEF
W 100 0 12345678
R 000 05002C18
R 003 3C810456
R 010 11223344
R 011 19BB6EDD
R 020 DEF2A007
W 003 1 00000099
R 003 3C810499

// File: verification/ad9528_spi_model.sv
`timescale 1ns/1ps
`include "cg_settings.svh"

module ad9528_spi_model (
    input  logic cs_n,
    input  logic sck,
    input  logic mosi,
    output logic miso
);
    import cg_regmap_pkg::*;

    localparam int LOG_DEPTH = 64;

    byte_t       regs [2048];
    logic [23:0] rx_frame;
    int          bit_cnt;
    byte_t       rd_byte;
    byte_addr_t  log_addr [LOG_DEPTH];  // write frames in arrival order
    byte_t       log_data [LOG_DEPTH];
    int          log_count;
    int          sweep_count;            // read frames at the last map address
    int          bad_frames;

    initial begin
        for (int a = 0; a < 2048; a++) begin
            regs[a] = 8'(a ^ (a >> 3) ^ 'h5a);  // every address bit shows up
        end
        rx_frame    = '0;
        bit_cnt     = 0;
        rd_byte     = '0;
        log_count   = 0;
        sweep_count = 0;
        bad_frames  = 0;
        miso        = 1'b0;
    end

    task automatic preload_byte(input byte_addr_t addr, input byte_t data);
        regs[addr] = data;
    endtask

    always @(negedge cs_n) begin
        bit_cnt  = 0;
        rx_frame = '0;
    end

    always @(posedge sck) begin
        if (cs_n == 1'b0) begin
            rx_frame = {rx_frame[22:0], mosi};
            bit_cnt  = bit_cnt + 1;
            if (bit_cnt == 16) begin
                rd_byte = regs[rx_frame[10:0]];  // header complete
            end
        end
    end

    // data bits go out after each falling edge
    always @(negedge sck) begin
        if (cs_n == 1'b0 && bit_cnt >= 16 && bit_cnt < 24) begin
            miso <= rd_byte[3'(23 - bit_cnt)];
        end
    end

    always @(posedge cs_n) begin
        if (bit_cnt != 0) begin
            if (bit_cnt != 24 || rx_frame[22:19] != 4'h0) begin
                bad_frames++;  // wrong length or multi-byte
            end else if (rx_frame[23]) begin
                if (rx_frame[18:8] == `CG_READBACK_LAST) begin
                    sweep_count++;
                end
            end else begin
                regs[rx_frame[18:8]] = rx_frame[7:0];
                if (log_count < LOG_DEPTH) begin
                    log_addr[log_count] = rx_frame[18:8];
                    log_data[log_count] = rx_frame[7:0];
                end
                log_count++;
            end
        end
        bit_cnt = 0;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/cg_regmap_pkg.sv
rtl/cg_ctrl_pkg.sv
rtl/write_queue.sv
rtl/spi_master.sv
rtl/cfg_sequencer.sv
rtl/shadow_regmap.sv
rtl/ad9528_cfg_top.sv
verification/ad9528_spi_model.sv
verification/ad9528_cfg_tb.sv
